/* logic/rv_core_pkg.sv */
/*
 * rv_core_pkg
 * shared types for the rv32i execute core: opcodes, alu operation codes,
 * control struct, instruction format views, memory request and retire record
 */

package rv_core_pkg;

	localparam int xlen      = 32;
	localparam int reg_count = 32; // architectural registers x0..x31

	typedef logic [xlen-1:0]                word_t;
	typedef logic [$clog2(reg_count)-1:0]   reg_addr_t;
	typedef logic [2:0]                     func3_t;
	typedef logic [6:0]                     func7_t;

	// major opcodes, rv32i encoding
	typedef enum logic [6:0] {
		nop_op_c    = 7'b0000000,
		r_type      = 7'b0110011,
		i_type_arth = 7'b0010011,
		i_type_load = 7'b0000011,
		s_type      = 7'b0100011,
		sb_type     = 7'b1100011
	} opcode_t;

	typedef enum logic [3:0] {
		add_op, sub_op, sll_op, slt_op, sltu_op, xor_op, srl_op, sra_op, or_op, and_op,
		eq_op, not_eq_op, less_than_op, greater_equal_than_op // branch compares
	} alu_op_t;

	typedef enum logic {src_reg2, immediate} alu_src_t;

	typedef enum logic [1:0] {no_mem_op, mem_read, mem_write} mem_op_t;

	typedef struct packed {
		alu_op_t  alu_op;
		alu_src_t alu_src;
		mem_op_t  memory_op;
		logic     is_branch_op;
		logic     reg_wb;
	} control_t; // 9 bits

	// one instruction word, fields sit differently per format
	typedef union packed {
		struct packed {
			func7_t funct7; reg_addr_t rs2; reg_addr_t rs1;
			func3_t funct3; reg_addr_t rd; logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm; reg_addr_t rs1;
			func3_t funct3; reg_addr_t rd; logic [6:0] opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi; reg_addr_t rs2; reg_addr_t rs1;
			func3_t funct3; logic [4:0] imm_lo; logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic imm_12; logic [5:0] imm_10_5; reg_addr_t rs2; reg_addr_t rs1;
			func3_t funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
		} b_fmt;
	} instr_word_u;

	typedef struct packed {
		word_t     rs1_data;
		word_t     rs2_data;
		word_t     imm;
		reg_addr_t rd;
		opcode_t   opcode;
		func3_t    funct3;
		func7_t    funct7;
		word_t     pc;
	} decoded_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic  read;
		logic  write;
	} mem_req_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     value;
		logic      reg_wb;
		logic      branch_taken;
		word_t     branch_target;
	} retire_t;

endpackage

/* logic/instr_decoder.sv */
/*
 * instr_decoder
 * splits the instruction word into fields, builds the sign extended
 * immediate per format and reads both source registers
 */

`timescale 1ns/1ps

module instr_decoder import rv_core_pkg::*; (
	input  logic        instr_valid,
	input  instr_word_u instr,
	input  word_t       pc,
	output reg_addr_t   rd_addr1,
	output reg_addr_t   rd_addr2,
	input  word_t       rd_data1,
	input  word_t       rd_data2,
	output decoded_t    decoded
);

	opcode_t opcode;
	word_t   imm;

	assign opcode = opcode_t'(instr.r_fmt.opcode); // same bits in every view

	// rs1/rs2 sit in the same place for r, s and b formats
	assign rd_addr1 = instr_valid ? instr.r_fmt.rs1 : '0;
	assign rd_addr2 = instr_valid ? instr.r_fmt.rs2 : '0;

	always_comb begin
		case (opcode)
			i_type_arth, i_type_load:
				imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
			s_type:
				imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
			sb_type: // halfword offset, bit 0 always zero
				imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
					instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
			default:
				imm = '0; // r-type and nop
		endcase
	end

	always_comb begin
		decoded.rs1_data = rd_data1;
		decoded.rs2_data = rd_data2;
		decoded.imm      = imm;
		decoded.rd       = instr.r_fmt.rd;
		decoded.opcode   = opcode;
		decoded.funct3   = instr.r_fmt.funct3;
		decoded.funct7   = instr.r_fmt.funct7;
		decoded.pc       = pc;
		if (opcode == s_type || opcode == sb_type)
			decoded.rd = '0; // rd slot holds immediate bits here
		if (!instr_valid) begin // idle cycle looks like a nop downstream
			decoded.opcode = nop_op_c;
			decoded.rd     = '0;
			decoded.funct3 = '0;
			decoded.funct7 = '0;
			decoded.imm    = '0;
		end
	end

endmodule

/* logic/control_unit.sv */
/*
 * control_unit
 * opcode, funct3 and funct7 to alu operation, operand source,
 * memory operation, branch flag and write-back enable
 */

`timescale 1ns/1ps

module control_unit import rv_core_pkg::*; (
	input  opcode_t  opcode,
	input  func3_t   func3,
	input  func7_t   func7,
	output control_t control
);

	always_comb begin
		// nop defaults, also cover unknown opcodes
		control.alu_op       = add_op;
		control.alu_src      = src_reg2;
		control.memory_op    = no_mem_op;
		control.is_branch_op = 1'b0;
		control.reg_wb       = 1'b0;

		case (opcode)
			r_type: begin
				control.reg_wb = 1'b1;
				case (func3)
					3'd0: control.alu_op = func7[5] ? sub_op : add_op;
					3'd1: control.alu_op = sll_op;
					3'd2: control.alu_op = slt_op;
					3'd3: control.alu_op = sltu_op;
					3'd4: control.alu_op = xor_op;
					3'd5: control.alu_op = func7[5] ? sra_op : srl_op;
					3'd6: control.alu_op = or_op;
					default: control.alu_op = and_op; // funct3 7
				endcase
			end

			i_type_arth: begin
				control.alu_src = immediate;
				control.reg_wb  = 1'b1;
				case (func3)
					3'd0: control.alu_op = add_op; // no subi in rv32i
					3'd1: control.alu_op = sll_op;
					3'd2: control.alu_op = slt_op;
					3'd3: control.alu_op = sltu_op;
					3'd4: control.alu_op = xor_op;
					3'd5: control.alu_op = func7[5] ? sra_op : srl_op; // imm[10]
					3'd6: control.alu_op = or_op;
					default: control.alu_op = and_op;
				endcase
			end

			i_type_load: begin
				control.alu_src   = immediate; // address = rs1 + imm
				control.memory_op = mem_read;
				control.reg_wb    = 1'b1;
			end

			s_type: begin
				control.alu_src   = immediate;
				control.memory_op = mem_write;
			end

			sb_type: begin
				control.is_branch_op = 1'b1;
				case (func3)
					3'd0: control.alu_op = eq_op;
					3'd1: control.alu_op = not_eq_op;
					3'd4: control.alu_op = less_than_op;
					3'd5: control.alu_op = greater_equal_than_op;
					default: control.alu_op = add_op; // bltu/bgeu not supported, never taken
				endcase
			end

			default: ; // nop
		endcase
	end

endmodule

/* logic/register_file.sv */
/*
 * register_file
 * 32 x 32-bit integer registers, two async read ports,
 * one sync write port, x0 hardwired to zero
 */

`timescale 1ns/1ps

module register_file import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  reg_addr_t rd_addr1,
	input  reg_addr_t rd_addr2,
	output word_t     rd_data1,
	output word_t     rd_data2,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	word_t regs [reg_count];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin // x0 never written
			regs[wr_addr] <= wr_data;
		end
	end

	// combinational read, new value visible the cycle after the write
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

/* logic/alu.sv */
/*
 * alu
 * arithmetic, logic, shift and set-less-than results
 * plus the branch condition for beq/bne/blt/bge
 */

`timescale 1ns/1ps

module alu import rv_core_pkg::*; (
	input  word_t   op_a,
	input  word_t   op_b,
	input  alu_op_t alu_op,
	output word_t   result,
	output logic    cond
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = op_b[4:0]; // only low 5 bits shift
	assign lt_signed   = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	always_comb begin
		result = '0;
		cond   = 1'b0;
		case (alu_op)
			add_op:  result = op_a + op_b;
			sub_op:  result = op_a - op_b;
			sll_op:  result = op_a << shamt;
			slt_op:  result = {{(xlen-1){1'b0}}, lt_signed};
			sltu_op: result = {{(xlen-1){1'b0}}, lt_unsigned};
			xor_op:  result = op_a ^ op_b;
			srl_op:  result = op_a >> shamt;
			sra_op:  result = word_t'($signed(op_a) >>> shamt); // sign fill
			or_op:   result = op_a | op_b;
			and_op:  result = op_a & op_b;
			// branch compares, result stays zero
			eq_op:                 cond = (op_a == op_b);
			not_eq_op:             cond = (op_a != op_b);
			less_than_op:          cond = lt_signed;
			greater_equal_than_op: cond = !lt_signed;
			default: ;
		endcase
	end

endmodule

/* logic/writeback_stage.sv */
/*
 * writeback_stage
 * drives the data memory request, picks the write-back value,
 * writes the register file and registers the retire record
 */

`timescale 1ns/1ps

module writeback_stage import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      instr_valid,
	input  decoded_t  decoded,
	input  control_t  control,
	input  word_t     result,
	input  logic      cond,
	input  word_t     load_data,
	output mem_req_t  mem_req,
	output logic      wr_en,
	output reg_addr_t wr_addr,
	output word_t     wr_data,
	output retire_t   retire
);

	retire_t retire_next;

	// memory port, combinational in the issue cycle
	assign mem_req.addr  = result; // rs1 + imm
	assign mem_req.wdata = decoded.rs2_data;
	assign mem_req.read  = instr_valid && control.memory_op == mem_read;
	assign mem_req.write = instr_valid && control.memory_op == mem_write;

	assign wr_en   = instr_valid && control.reg_wb;
	assign wr_addr = decoded.rd;
	assign wr_data = (control.memory_op == mem_read) ? load_data : result;

	always_comb begin
		retire_next.valid         = instr_valid;
		retire_next.rd            = decoded.rd;
		retire_next.value         = wr_data;
		retire_next.reg_wb        = wr_en;
		retire_next.branch_taken  = instr_valid && control.is_branch_op && cond;
		retire_next.branch_target = decoded.pc + decoded.imm; // pc-relative
	end

	// control bits cleared on reset, payload just follows
	always_ff @(posedge clk) begin
		if (reset) begin
			retire.valid        <= 1'b0;
			retire.reg_wb       <= 1'b0;
			retire.branch_taken <= 1'b0;
		end else begin
			retire <= retire_next;
		end
	end

endmodule

/* logic/rv_exec_core.sv */
/*
 * rv_exec_core
 * single-issue rv32i execute core, decode, control, alu and
 * write-back in one cycle, retire record one cycle later
 */

`timescale 1ns/1ps

module rv_exec_core import rv_core_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        instr_valid,
	input  instr_word_u instr,
	input  word_t       pc,
	input  word_t       load_data,
	output mem_req_t    mem_req,
	output retire_t     retire
);

	reg_addr_t rd_addr1, rd_addr2, wr_addr;
	word_t     rd_data1, rd_data2, wr_data;
	logic      wr_en;
	decoded_t  decoded;
	control_t  control;
	word_t     op_b, result;
	logic      cond;

	instr_decoder u_decoder (.instr_valid, .instr, .pc, .rd_addr1, .rd_addr2,
		.rd_data1, .rd_data2, .decoded);

	control_unit u_control (.opcode(decoded.opcode), .func3(decoded.funct3),
		.func7(decoded.funct7), .control);

	register_file u_regfile (.clk, .reset, .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
		.wr_en, .wr_addr, .wr_data);

	assign op_b = (control.alu_src == immediate) ? decoded.imm : decoded.rs2_data;

	alu u_alu (.op_a(decoded.rs1_data), .op_b, .alu_op(control.alu_op), .result, .cond);

	writeback_stage u_wb (.clk, .reset, .instr_valid, .decoded, .control, .result, .cond,
		.load_data, .mem_req, .wr_en, .wr_addr, .wr_data, .retire);

endmodule

/* verification/rv_exec_core_assertions.sv */
/*
 * rv_exec_core_assertions
 * protocol checks on the memory port, the retire record and x0,
 * bound into every rv_exec_core instance
 */

`timescale 1ns/1ps

module rv_exec_core_assertions import rv_core_pkg::*; (
	input logic     clk,
	input logic     reset,
	input logic     instr_valid,
	input mem_req_t mem_req,
	input retire_t  retire,
	input word_t    x0_value
);

	int fail_count = 0; // tally of failed properties

	retire_low_after_reset: assert property (@(posedge clk) reset |=> !retire.valid)
		else begin
			fail_count++;
			$error("retire.valid high in the cycle after reset");
		end

	// a word access is either a load or a store
	no_read_and_write: assert property (@(posedge clk) disable iff (reset)
		!(mem_req.read && mem_req.write))
		else begin
			fail_count++;
			$error("mem_req.read and mem_req.write high together");
		end

	strobe_needs_valid: assert property (@(posedge clk) disable iff (reset)
		(mem_req.read || mem_req.write) |-> instr_valid)
		else begin
			fail_count++;
			$error("memory strobe without instr_valid");
		end

	retire_follows_valid: assert property (@(posedge clk) disable iff (reset)
		instr_valid |=> retire.valid)
		else begin
			fail_count++;
			$error("valid instruction did not retire one cycle later");
		end

	no_retire_when_idle: assert property (@(posedge clk) disable iff (reset)
		!instr_valid |=> !retire.valid)
		else begin
			fail_count++;
			$error("retire.valid high after an idle cycle");
		end

	x0_stays_zero: assert property (@(posedge clk) disable iff (reset) x0_value == '0)
		else begin
			fail_count++;
			$error("register x0 changed value");
		end

endmodule

bind rv_exec_core rv_exec_core_assertions u_assert (.clk, .reset, .instr_valid, .mem_req,
	.retire, .x0_value(u_regfile.regs[0]));

/* verification/rv_exec_core_tb.sv */
/*
 * rv_exec_core_tb
 * table driven testbench, reference register and memory model computes
 * expected retire records and memory requests for every row
 */

`timescale 1ns/1ps

module rv_exec_core_tb import rv_core_pkg::*; ();

	typedef struct packed {
		word_t instr;
		word_t pc;
		logic  valid;
	} row_t;

	typedef struct packed {
		retire_t  ret;
		mem_req_t mem;
		logic     is_branch; // compare branch_target too
	} exp_t;

	logic        clk;
	logic        reset;
	logic        instr_valid;
	instr_word_u instr;
	word_t       pc;
	word_t       load_data;
	mem_req_t    mem_req;
	retire_t     retire;

	row_t   rows [$];
	exp_t   exp_q [$];
	word_t  ref_regs [32]; // model register file
	word_t  ref_mem [64];  // model data memory
	word_t  mem_dev [64];  // memory seen by the DUT
	integer seed;
	int     mismatches;
	int     timeouts;

	rv_exec_core DUT (.clk, .reset, .instr_valid, .instr, .pc, .load_data, .mem_req, .retire);

	// combinational data memory, word index from addr[7:2]
	assign load_data = mem_dev[mem_req.addr[7:2]];

	always @(posedge clk)
		if (mem_req.write)
			mem_dev[mem_req.addr[7:2]] <= mem_req.wdata;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#5 reset = 1'b0;
	end

	// instruction format encoders
	function automatic word_t r_word(func7_t f7, func3_t f3, reg_addr_t rd, reg_addr_t rs1,
		reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, r_type};
	endfunction

	function automatic word_t i_word(opcode_t opc, logic [11:0] imm, func3_t f3,
		reg_addr_t rd, reg_addr_t rs1);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_word(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
		return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], s_type}; // sw only
	endfunction

	function automatic word_t b_word(logic [12:0] imm, func3_t f3, reg_addr_t rs1,
		reg_addr_t rs2);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], sb_type};
	endfunction

	function automatic word_t alu_model(func3_t f3, logic alt, word_t a, word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_model(func3_t f3, word_t a, word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			default: return 1'b0;
		endcase
	endfunction

	// one row through the model, updates ref_regs and ref_mem
	function automatic exp_t model_step(row_t r);
		exp_t      e;
		word_t     w, a, b, imm_i, imm_s, imm_b;
		reg_addr_t rd, rs1, rs2;
		func3_t    f3;
		e = '0;
		w = r.instr;
		rd = w[11:7];
		f3 = w[14:12];
		rs1 = w[19:15];
		rs2 = w[24:20];
		e.ret.valid = r.valid;
		if (!r.valid)
			return e; // idle row, nothing happens
		a = ref_regs[rs1];
		b = ref_regs[rs2];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		case (w[6:0])
			r_type: begin
				e.ret.reg_wb = 1'b1;
				e.ret.value = alu_model(f3, w[30], a, b);
			end
			i_type_arth: begin
				e.ret.reg_wb = 1'b1;
				e.ret.value = alu_model(f3, f3 == 3'd5 && w[30], a, imm_i); // only srai
			end
			i_type_load: begin
				e.ret.reg_wb = 1'b1;
				e.mem.read = 1'b1;
				e.mem.addr = a + imm_i;
				e.ret.value = ref_mem[e.mem.addr[7:2]];
			end
			s_type: begin
				e.mem.write = 1'b1;
				e.mem.addr = a + imm_s;
				e.mem.wdata = b;
				ref_mem[e.mem.addr[7:2]] = b;
			end
			sb_type: begin
				e.is_branch = 1'b1;
				e.ret.branch_taken = branch_model(f3, a, b);
				e.ret.branch_target = r.pc + imm_b;
			end
			default: ; // nop
		endcase
		e.ret.rd = e.ret.reg_wb ? rd : '0;
		if (e.ret.reg_wb && rd != '0)
			ref_regs[rd] = e.ret.value;
		return e;
	endfunction

	task automatic push_row(word_t w, logic v);
		row_t r;
		r.instr = w;
		r.pc = 32'h0000_1000 + 4 * rows.size();
		r.valid = v;
		rows.push_back(r);
	endtask

	task automatic check_word(string what, int row, word_t got, word_t exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s row %0d got %h expected %h", $time, what, row,
				got, exp);
			mismatches++;
		end
	endtask

	task automatic check_retire(int i);
		exp_t e;
		e = exp_q[i];
		check_word("retire.valid", i, retire.valid, e.ret.valid);
		check_word("retire.reg_wb", i, retire.reg_wb, e.ret.reg_wb);
		check_word("retire.branch_taken", i, retire.branch_taken, e.ret.branch_taken);
		if (e.ret.reg_wb) begin
			check_word("retire.rd", i, retire.rd, e.ret.rd);
			check_word("retire.value", i, retire.value, e.ret.value);
		end
		if (e.is_branch)
			check_word("retire.branch_target", i, retire.branch_target, e.ret.branch_target);
	endtask

	task automatic check_mem(int i);
		exp_t e;
		e = exp_q[i];
		check_word("mem_req.read", i, mem_req.read, e.mem.read);
		check_word("mem_req.write", i, mem_req.write, e.mem.write);
		if (e.mem.read || e.mem.write)
			check_word("mem_req.addr", i, mem_req.addr, e.mem.addr);
		if (e.mem.write)
			check_word("mem_req.wdata", i, mem_req.wdata, e.mem.wdata);
	endtask

	task automatic build_table();
		logic [11:0] i_imm [8];
		i_imm = '{12'h123, 12'h005, 12'hf80, 12'hf80, 12'h5a5, 12'h003, 12'h0ff, 12'h0f0};
		push_row(32'hdead_beef, 1'b0); // garbage while idle
		push_row(r_word(7'h00, 3'd0, 5'd1, 5'd2, 5'd3), 1'b0);
		for (int k = 0; k < 16; k++) // every register read once, all zero
			push_row(r_word(7'h00, 3'd0, 2 * k + 1, 2 * k, 2 * k + 1), 1'b1);
		for (int k = 1; k <= 8; k++) // x1..x8 from random memory
			push_row(i_word(i_type_load, 4 * k, 3'd2, k, 5'd0), 1'b1);
		push_row(i_word(i_type_arth, 12'hffb, 3'd0, 5'd22, 5'd0), 1'b1); // x22 = -5
		for (int f = 0; f < 8; f++)
			push_row(r_word(7'h00, f, 10 + f, 5'd1, 5'd2), 1'b1);
		push_row(r_word(7'h20, 3'd0, 5'd18, 5'd3, 5'd4), 1'b1); // sub
		push_row(r_word(7'h20, 3'd5, 5'd19, 5'd22, 5'd2), 1'b1); // sra of negative
		push_row(r_word(7'h00, 3'd5, 5'd20, 5'd22, 5'd2), 1'b1); // srl, zero fill
		push_row(r_word(7'h00, 3'd2, 5'd21, 5'd22, 5'd1), 1'b1); // slt vs sltu
		push_row(r_word(7'h00, 3'd3, 5'd23, 5'd22, 5'd1), 1'b1);
		for (int f = 0; f < 8; f++)
			push_row(i_word(i_type_arth, i_imm[f], f, 24 + f, f[0] ? 5'd22 : 5'd1), 1'b1);
		push_row(i_word(i_type_arth, 12'h403, 3'd5, 5'd9, 5'd22), 1'b1); // srai
		push_row(s_word(12'h030, 5'd10, 5'd0), 1'b1);
		push_row(i_word(i_type_load, 12'h030, 3'd2, 5'd26, 5'd0), 1'b1); // reads the store
		push_row(s_word(12'h034, 5'd22, 5'd1), 1'b1);
		push_row(i_word(i_type_load, 12'h034, 3'd2, 5'd27, 5'd1), 1'b1);
		push_row(b_word(13'h0010, 3'd0, 5'd1, 5'd1), 1'b1); // beq taken
		push_row(b_word(13'h1ff8, 3'd0, 5'd1, 5'd2), 1'b1); // backward offset
		push_row(b_word(13'h0020, 3'd1, 5'd1, 5'd2), 1'b1);
		push_row(b_word(13'h1000, 3'd1, 5'd3, 5'd3), 1'b1); // most negative offset
		push_row(b_word(13'h000c, 3'd4, 5'd22, 5'd1), 1'b1);
		push_row(b_word(13'h0008, 3'd4, 5'd1, 5'd22), 1'b1);
		push_row(b_word(13'h1fec, 3'd5, 5'd22, 5'd1), 1'b1);
		push_row(b_word(13'h0008, 3'd5, 5'd1, 5'd1), 1'b1);
		push_row(32'h0000_0000, 1'b1); // nop
		push_row(r_word(7'h00, 3'd0, 5'd5, 5'd1, 5'd2), 1'b0); // dropped, x5 kept
		push_row(r_word(7'h00, 3'd0, 5'd28, 5'd5, 5'd0), 1'b1);
		push_row(r_word(7'h00, 3'd0, 5'd0, 5'd1, 5'd2), 1'b1); // write to x0
		push_row(i_word(i_type_load, 12'h004, 3'd2, 5'd0, 5'd0), 1'b1);
		push_row(r_word(7'h00, 3'd0, 5'd28, 5'd0, 5'd1), 1'b1); // x0 still zero
		push_row(i_word(i_type_arth, 12'h007, 3'd0, 5'd29, 5'd1), 1'b1);
		push_row(r_word(7'h00, 3'd0, 5'd30, 5'd29, 5'd29), 1'b1); // back to back
	endtask

	initial begin
		int cycles;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		mismatches = 0;
		timeouts = 0;
		seed = 32'hcce3_aa85;
		for (int a = 0; a < 64; a++) begin
			mem_dev[a] = $random(seed);
			ref_mem[a] = mem_dev[a];
		end
		for (int r = 0; r < 32; r++)
			ref_regs[r] = '0;
		build_table();
		foreach (rows[i])
			exp_q.push_back(model_step(rows[i]));

		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (reset && cycles < 20);
		if (reset) begin
			$display("Timeout: reset still asserted after %0d cycles", cycles);
			timeouts++;
		end else begin
			#5;
			check_word("retire.valid after reset", -1, retire.valid, 1'b0);
			check_word("mem_req.read after reset", -1, mem_req.read, 1'b0);
			check_word("mem_req.write after reset", -1, mem_req.write, 1'b0);
			for (int i = 0; i < rows.size(); i++) begin
				@(posedge clk);
				#5;
				if (i > 0)
					check_retire(i - 1); // previous row retired at this edge
				instr_valid = rows[i].valid;
				instr = rows[i].instr;
				pc = rows[i].pc;
				#40 check_mem(i); // combinational request settled
			end
			@(posedge clk);
			#5;
			check_retire(rows.size() - 1);
			instr_valid = 1'b0;
			instr = '0;
			@(posedge clk);
			#5;
			check_word("retire.valid idle", rows.size(), retire.valid, 1'b0);
		end

		$display("Error counts: %0d mismatches, %0d assertion failures, %0d timeouts",
			mismatches, DUT.u_assert.fail_count, timeouts);
		if (mismatches == 0 && timeouts == 0 && DUT.u_assert.fail_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* sources.f */
logic/rv_core_pkg.sv
logic/instr_decoder.sv
logic/control_unit.sv
logic/register_file.sv
logic/alu.sv
logic/writeback_stage.sv
logic/rv_exec_core.sv
verification/rv_exec_core_assertions.sv
verification/rv_exec_core_tb.sv

/* Bender.yml */
package:
  name: rv_exec_core

sources:
  - logic/rv_core_pkg.sv
  - logic/instr_decoder.sv
  - logic/control_unit.sv
  - logic/register_file.sv
  - logic/alu.sv
  - logic/writeback_stage.sv
  - logic/rv_exec_core.sv
  - target: simulation
    files:
      - verification/rv_exec_core_assertions.sv
      - verification/rv_exec_core_tb.sv
